/* fpu_pkg.sv */
// Shared widths, encodings and stage records for the binary64 pipeline.
// Each stage module imports this package and passes one struct per cycle.
package fpu_pkg;

    localparam int word_w   = 64;
    localparam int exp_w    = 12;
    localparam int exp_bias = 2047;     // internal exponent bias
    localparam int dp_bias  = 1023;
    localparam int exp_inf  = 3967;     // infinity / overflow marker
    localparam int lead_pos = 55;       // hidden one sits here
    localparam int tag_w    = 8;

    typedef enum logic [2:0] {
        op_add, op_sub, op_min, op_max, op_eq, op_lt, op_le
    } fpu_op_e;

    typedef enum logic [2:0] {
        rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm
    } round_mode_e;

    typedef struct packed {
        fpu_op_e           op;
        round_mode_e       rm;
        logic [tag_w-1:0]  tag;
        logic [word_w-1:0] a;
        logic [word_w-1:0] b;
    } fpu_req_t;

    typedef struct packed {
        logic        sign;
        logic [10:0] exp;
        logic [51:0] frac;
    } dp_fields_t;

    // one operand word seen either raw or split into fields
    typedef union packed {
        logic [word_w-1:0] bits;
        dp_fields_t        fields;
    } fp_word_u;

    typedef struct packed {
        logic              sign;
        logic [exp_w-1:0]  exp;
        logic [word_w-1:0] man;
    } unpacked_t;

    typedef struct packed {
        logic             valid;
        fpu_op_e          op;
        round_mode_e      rm;
        logic [tag_w-1:0] tag;
    } ctl_t;

    typedef struct packed {
        ctl_t      ctl;
        unpacked_t a;
        unpacked_t b;
    } split_t;

    typedef struct packed {
        ctl_t              ctl;
        unpacked_t         a;
        unpacked_t         b;
        logic [word_w-1:0] a2;      // aligned two's complement
        logic [word_w-1:0] b2;
        logic [exp_w-1:0]  max_exp;
    } align_t;

    typedef struct packed {
        ctl_t              ctl;
        logic              is_int;
        logic              sign;
        logic [exp_w-1:0]  exp;
        logic [word_w-1:0] man;
        logic [word_w-1:0] int_res;
    } calc_t;

    typedef calc_t norm_t;          // same layout, mantissa renormalized

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        fp_word_u         result;
    } fpu_resp_t;

    // right shift that folds every lost bit into bit 0
    function automatic logic [word_w-1:0] sticky_shr(input logic [word_w-1:0] m,
                                                     input logic [exp_w-1:0]  shamt);
        logic [word_w-1:0] r;
        r    = m >> shamt[5:0];
        r[0] = r[0] | (|(m & ((64'd1 << shamt[5:0]) - 64'd1)));
        if (shamt >= 12'(word_w)) r = {63'd0, |m};  // everything shifted out
        return r;
    endfunction

endpackage

/* fpu_unpack.sv */
// Pipeline stage 1. Splits both binary64 operands into sign, internal
// exponent and a 64-bit mantissa with the hidden one at lead_pos.
`timescale 1ns/1ps

module fpu_unpack
    import fpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  fpu_req_t req,
    output split_t   split
);

    function automatic unpacked_t unpack_op(input fp_word_u w);
        unpacked_t u;
        u.sign = w.fields.sign;
        u.exp  = {1'b0, w.fields.exp} - exp_w'(dp_bias) + exp_w'(exp_bias);
        u.man  = {9'd1, w.fields.frac, 3'd0};               // hidden one at bit 55
        if (w.fields.exp == 11'd0) begin
            u.man = {9'd0, w.fields.frac, 3'd0} << 1;       // zero or subnormal
        end
        if (&w.fields.exp) u.exp = exp_w'(exp_inf);         // nan handled as inf
        return u;
    endfunction

    fp_word_u word_a, word_b;

    assign word_a.bits = req.a;
    assign word_b.bits = req.b;

    always_ff @(posedge clk) begin
        if (rst) begin
            split.ctl.valid <= 1'b0;
        end else begin
            split.ctl.valid <= in_valid;
        end
        split.ctl.op  <= req.op;
        split.ctl.rm  <= req.rm;
        split.ctl.tag <= req.tag;
        split.a       <= unpack_op(word_a);
        split.b       <= unpack_op(word_b);
    end

endmodule

/* fpu_align.sv */
// Pipeline stage 2. Shifts both mantissas to the larger exponent with a
// sticky shift and turns negative operands into two's complement.
`timescale 1ns/1ps

module fpu_align
    import fpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  split_t split,
    output align_t align
);

    function automatic logic [word_w-1:0] align_op(input unpacked_t u,
                                                   input logic [exp_w-1:0] max_exp);
        logic [word_w-1:0] m;
        m = sticky_shr(u.man, max_exp - u.exp);
        if (u.sign) m = ~m + 64'd1;
        return m;
    endfunction

    logic [exp_w-1:0]  max_exp;
    logic [word_w-1:0] a2, b2;

    assign max_exp = (split.a.exp > split.b.exp) ? split.a.exp : split.b.exp;
    assign a2      = align_op(split.a, max_exp);
    assign b2      = align_op(split.b, max_exp);

    always_ff @(posedge clk) begin
        if (rst) begin
            align.ctl.valid <= 1'b0;
        end else begin
            align.ctl.valid <= split.ctl.valid;
        end
        align.ctl.op  <= split.ctl.op;
        align.ctl.rm  <= split.ctl.rm;
        align.ctl.tag <= split.ctl.tag;
        align.a       <= split.a;           // kept whole for min/max
        align.b       <= split.b;
        align.a2      <= a2;
        align.b2      <= b2;
        align.max_exp <= max_exp;
    end

endmodule

/* fpu_calc.sv */
// Pipeline stage 3. Adds or subtracts the aligned mantissas, evaluates
// the compares as 0/1 integers and picks the operand for min and max.
`timescale 1ns/1ps

module fpu_calc
    import fpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  align_t align,
    output calc_t  calc
);

    logic [word_w-1:0] sum;
    logic              a_lt_b, a_eq_b;
    calc_t             nxt;

    assign a_lt_b = $signed(align.a2) < $signed(align.b2);
    assign a_eq_b = align.a2 == align.b2;

    // upper 63 bits as two's complement, bit 0 stays sticky
    always_comb begin
        if (align.ctl.op == op_sub) begin
            sum[63:1] = align.a2[63:1] - align.b2[63:1];
        end else begin
            sum[63:1] = align.a2[63:1] + align.b2[63:1];
        end
        sum[0] = align.a2[0] | align.b2[0];
    end

    always_comb begin
        nxt         = '0;
        nxt.ctl     = align.ctl;
        case (align.ctl.op)
            op_add, op_sub: begin
                nxt.sign = sum[63];
                nxt.exp  = align.max_exp;
                nxt.man  = sum[63] ? ~sum + 64'd1 : sum;    // magnitude
            end
            op_min: begin
                {nxt.sign, nxt.exp, nxt.man} = a_lt_b ? align.a : align.b;
            end
            op_max: begin
                {nxt.sign, nxt.exp, nxt.man} = (!a_lt_b && !a_eq_b) ? align.a : align.b;
            end
            op_eq: begin
                nxt.is_int  = 1'b1;
                nxt.int_res = {63'd0, a_eq_b};
            end
            op_lt: begin
                nxt.is_int  = 1'b1;
                nxt.int_res = {63'd0, a_lt_b};
            end
            op_le: begin
                nxt.is_int  = 1'b1;
                nxt.int_res = {63'd0, a_lt_b | a_eq_b};
            end
            default: nxt.is_int = 1'b1;     // unused code gives integer 0
        endcase
    end

    always_ff @(posedge clk) begin
        calc <= nxt;
        if (rst) calc.ctl.valid <= 1'b0;
    end

endmodule

/* fpu_normalize.sv */
// Pipeline stage 4. Moves the highest set mantissa bit to lead_pos and
// corrects the exponent, clamping underflow, overflow and zero results.
`timescale 1ns/1ps

module fpu_normalize
    import fpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  calc_t calc,
    output norm_t norm
);

    logic [5:0]  hi;            // position of highest one
    logic        found;
    logic [12:0] e_sum;
    norm_t       nxt;

    always_comb begin
        hi    = 6'd0;
        found = 1'b0;
        for (int i = 0; i < word_w; i++) begin
            if (calc.man[i]) begin
                hi    = 6'(i);
                found = 1'b1;
            end
        end
    end

    assign e_sum = 13'(calc.exp) + 13'(hi);

    always_comb begin
        nxt = calc;
        if (!calc.is_int) begin
            nxt.exp = calc.exp + 12'(hi) - 12'(lead_pos);
            if (hi > 6'(lead_pos)) begin
                nxt.man = sticky_shr(calc.man, 12'(hi) - 12'(lead_pos));
            end else begin
                nxt.man = calc.man << (6'(lead_pos) - hi);
            end
            if (e_sum < 13'(lead_pos)) nxt.exp = '0;                    // underflow
            if (e_sum > 13'(lead_pos + (1 << exp_w) - 1)) begin
                nxt.exp = exp_w'(exp_inf);                              // overflow
            end
            if (!found) begin
                nxt.exp = '0;
                nxt.man = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        norm <= nxt;
        if (rst) norm.ctl.valid <= 1'b0;
    end

endmodule

/* fpu_round_pack.sv */
// Pipeline stage 5. Rounds at bit 3 by the request's mode, handles
// subnormal and infinite results and packs the binary64 or integer word.
`timescale 1ns/1ps

module fpu_round_pack
    import fpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  norm_t     norm,
    output fpu_resp_t resp
);

    logic              inc;
    logic [word_w-1:0] m;
    logic [exp_w-1:0]  e;
    fp_word_u          word;

    always_comb begin
        case (norm.ctl.rm)
            rm_rne:  inc = norm.man[2] & (|norm.man[1:0] | norm.man[3]);
            rm_rdn:  inc = norm.sign & |norm.man[2:0];
            rm_rup:  inc = ~norm.sign & |norm.man[2:0];
            rm_rmm:  inc = norm.man[2];
            default: inc = 1'b0;            // rtz
        endcase
    end

    always_comb begin
        m = norm.man + {60'd0, inc, 3'd0};
        e = norm.exp;
        if (m[lead_pos+1]) begin        // carry out of the leading bit
            e = e + 12'd1;
            m = m >> 1;
        end
        if (e < exp_w'(exp_bias - dp_bias + 1)) begin
            // below min normal, shift into a subnormal
            if (e > exp_w'(exp_bias - dp_bias + 1 - 53)) begin
                m = m >> (exp_w'(exp_bias - dp_bias + 1) - e);
            end else begin
                m = '0;
            end
            e = exp_w'(exp_bias - dp_bias);
        end
        word.fields.sign = norm.sign;
        word.fields.exp  = 11'(e - exp_w'(exp_bias - dp_bias));
        word.fields.frac = m[lead_pos-1:3];
        if (e >= exp_w'(exp_bias + dp_bias + 1)) begin
            word.fields.exp  = '1;      // +/- infinity
            word.fields.frac = '0;
        end
        if (norm.is_int) word.bits = norm.int_res;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= norm.ctl.valid;
        end
        resp.tag    <= norm.ctl.tag;
        resp.result <= word;
    end

endmodule

/* fpu_top.sv */
// Top level of the five-stage binary64 add/compare pipeline.
// One request per cycle, each result out exactly five cycles later.
`timescale 1ns/1ps

module fpu_top
    import fpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  fpu_req_t  req,
    output fpu_resp_t resp
);

    split_t s_split;
    align_t s_align;
    calc_t  s_calc;
    norm_t  s_norm;

    fpu_unpack i_unpack (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .req      (req),
        .split    (s_split)
    );

    fpu_align i_align (
        .clk   (clk),
        .rst   (rst),
        .split (s_split),
        .align (s_align)
    );

    fpu_calc i_calc (
        .clk   (clk),
        .rst   (rst),
        .align (s_align),
        .calc  (s_calc)
    );

    fpu_normalize i_normalize (
        .clk  (clk),
        .rst  (rst),
        .calc (s_calc),
        .norm (s_norm)
    );

    fpu_round_pack i_round_pack (
        .clk  (clk),
        .rst  (rst),
        .norm (s_norm),
        .resp (resp)
    );

endmodule

/* fpu_props.sv */
// Assertions on the top-level strobes, bound into fpu_top by the testbench.
`timescale 1ns/1ps

module fpu_props
    import fpu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      in_valid,
    input fpu_req_t  req,
    input fpu_resp_t resp
);

    int         fail_count = 0;
    logic [2:0] since_rst;      // edges since reset, stops at 5

    always_ff @(posedge clk) begin
        if (rst) begin
            since_rst <= '0;
        end else if (since_rst != 3'd5) begin
            since_rst <= since_rst + 3'd1;
        end
    end

    a_quiet_after_rst: assert property (@(posedge clk) disable iff (rst)
        since_rst < 3'd5 |-> !resp.valid)
        else begin
            $error("out_valid high within 5 cycles of reset");
            fail_count++;
        end

    a_valid_latency: assert property (@(posedge clk) disable iff (rst)
        since_rst == 3'd5 |-> resp.valid == $past(in_valid, 5))
        else begin
            $error("out_valid does not follow in_valid by 5 cycles");
            fail_count++;
        end

    a_tag_latency: assert property (@(posedge clk) disable iff (rst)
        resp.valid |-> resp.tag == $past(req.tag, 5))
        else begin
            $error("output tag differs from the request tag 5 cycles earlier");
            fail_count++;
        end

endmodule

/* fpu_checker.sv */
// Scoreboard for the FPU pipeline. The testbench pushes tag and expected
// word per request; each out_valid pops one entry and is compared in order.
`timescale 1ns/1ps

module fpu_checker
    import fpu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input fpu_resp_t resp
);

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [word_w-1:0] value;
    } expect_t;

    expect_t exp_q[$];
    int      n_pass = 0;
    int      n_fail = 0;

    task automatic push_expected(input logic [tag_w-1:0] tag, input logic [word_w-1:0] value);
        expect_t e;
        e.tag   = tag;
        e.value = value;
        exp_q.push_back(e);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // results arrive in request order, so the head is always the match
    always @(posedge clk) begin
        expect_t e;
        if (!rst && resp.valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected result with tag 0x%02h while nothing was outstanding",
                         resp.tag);
                n_fail++;
            end else begin
                e = exp_q.pop_front();
                if (resp.result.bits === e.value && resp.tag === e.tag) begin
                    $display("PASS tag 0x%02h result 0x%016h", resp.tag, resp.result.bits);
                    n_pass++;
                end else begin
                    $display("FAIL resp.result 0x%016h want 0x%016h, resp.tag 0x%02h want 0x%02h",
                             resp.result.bits, e.value, resp.tag, e.tag);
                    n_fail++;
                end
            end
        end
    end

    task automatic report_counts(input int assert_fails);
        if (exp_q.size() != 0) begin
            $display("%0d results never came out of the pipeline", exp_q.size());
            n_fail += exp_q.size();
        end
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 n_pass + n_fail, n_pass, n_fail, assert_fails);
    endtask

endmodule

/* tb_fpu.sv */
// Testbench for the binary64 add/compare pipeline. Applies a table of
// directed rows and a short LCG tail, one request per cycle, into fpu_top.
`timescale 1ns/1ps

module tb_fpu
    import fpu_pkg::*;
();

    typedef struct packed {
        fpu_op_e           op;
        round_mode_e       rm;
        logic [word_w-1:0] a;
        logic [word_w-1:0] b;
        logic [word_w-1:0] expv;
    } row_t;

    logic      clk;
    logic      rst;
    logic      in_valid;
    fpu_req_t  req;
    fpu_resp_t resp;

    row_t        rows[$];
    logic [31:0] seed   = 32'd41;
    int          cycles = 0;
    int          limit  = 1000;     // replaced once the table is built
    bit          done   = 1'b0;

    fpu_top i_fpu_top (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .req      (req),
        .resp     (resp)
    );

    fpu_checker i_checker (
        .clk  (clk),
        .rst  (rst),
        .resp (resp)
    );

    bind fpu_top fpu_props i_props (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .req      (req),
        .resp     (resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // order of two finite nonzero words by sign, then magnitude
    function automatic logic less_than(input logic [63:0] x, input logic [63:0] y);
        if (x[63] != y[63]) return x[63];
        if (x[63]) return x[62:0] > y[62:0];   // larger magnitude is smaller
        return x[62:0] < y[62:0];
    endfunction

    task automatic add_row(input fpu_op_e op, input round_mode_e rm,
                           input logic [63:0] a, input logic [63:0] b,
                           input logic [63:0] expv);
        row_t r;
        r.op   = op;
        r.rm   = rm;
        r.a    = a;
        r.b    = b;
        r.expv = expv;
        rows.push_back(r);
    endtask

    // finite normal with exponent field 1020..1027
    task automatic next_normal(output logic [63:0] w);
        logic [31:0] hi;
        seed = lcg(seed);
        hi   = seed;
        seed = lcg(seed);
        w    = {hi[31], 11'd1020 + 11'(hi[2:0]), hi[30:11], seed};
    endtask

    task automatic add_random_rows(input int n);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] expv;
        fpu_op_e     op;
        int          sel;
        for (int i = 0; i < n; i++) begin
            next_normal(a);
            next_normal(b);
            if (seed[7:5] == 3'd0) b = a;       // equal pair now and then
            sel = int'(seed[18:16]) % 5;
            case (sel)
                0: begin
                    op   = op_eq;
                    expv = {63'd0, a == b};
                end
                1: begin
                    op   = op_lt;
                    expv = {63'd0, less_than(a, b)};
                end
                2: begin
                    op   = op_le;
                    expv = {63'd0, less_than(a, b) | (a == b)};
                end
                3: begin
                    op   = op_min;
                    expv = less_than(a, b) ? a : b;
                end
                default: begin
                    op   = op_max;
                    expv = less_than(b, a) ? a : b;
                end
            endcase
            add_row(op, rm_rne, a, b, expv);
        end
    endtask

    task automatic build_table();
        // exact add and subtract
        add_row(op_add, rm_rne, 64'h3FF0000000000000, 64'h4000000000000000, 64'h4008000000000000);
        add_row(op_sub, rm_rne, 64'h4016000000000000, 64'h4020000000000000, 64'hC004000000000000);
        add_row(op_sub, rm_rne, 64'h3FF8000000000000, 64'h3FF8000000000000, 64'h0000000000000000);
        // 1.0 + 2^-53 under each mode, then a tie that goes to even
        add_row(op_add, rm_rne, 64'h3FF0000000000000, 64'h3CA0000000000000, 64'h3FF0000000000000);
        add_row(op_add, rm_rtz, 64'h3FF0000000000000, 64'h3CA0000000000000, 64'h3FF0000000000000);
        add_row(op_add, rm_rdn, 64'h3FF0000000000000, 64'h3CA0000000000000, 64'h3FF0000000000000);
        add_row(op_add, rm_rup, 64'h3FF0000000000000, 64'h3CA0000000000000, 64'h3FF0000000000001);
        add_row(op_add, rm_rmm, 64'h3FF0000000000000, 64'h3CA0000000000000, 64'h3FF0000000000001);
        add_row(op_add, rm_rne, 64'h3FF0000000000001, 64'h3CA0000000000000, 64'h3FF0000000000002);
        add_row(op_add, rm_rdn, 64'hBFF0000000000000, 64'hBCA0000000000000, 64'hBFF0000000000001);
        add_row(op_add, rm_rup, 64'hBFF0000000000000, 64'hBCA0000000000000, 64'hBFF0000000000000);
        // compares give integer 0/1, min/max give the operand word
        add_row(op_eq,  rm_rne, 64'h3FF0000000000000, 64'h3FF0000000000000, 64'h1);
        add_row(op_eq,  rm_rne, 64'h3FF0000000000000, 64'h4000000000000000, 64'h0);
        add_row(op_lt,  rm_rne, 64'h3FF0000000000000, 64'h4000000000000000, 64'h1);
        add_row(op_lt,  rm_rne, 64'hBFF0000000000000, 64'h3FF0000000000000, 64'h1);
        add_row(op_le,  rm_rne, 64'h4000000000000000, 64'h3FF0000000000000, 64'h0);
        add_row(op_le,  rm_rne, 64'hC008000000000000, 64'hC008000000000000, 64'h1);
        add_row(op_lt,  rm_rne, 64'h4000000000000000, 64'hC008000000000000, 64'h0);
        add_row(op_min, rm_rne, 64'h4008000000000000, 64'hC004000000000000, 64'hC004000000000000);
        add_row(op_max, rm_rne, 64'h4008000000000000, 64'hC004000000000000, 64'h4008000000000000);
        add_row(op_min, rm_rne, 64'hBFF0000000000000, 64'hC008000000000000, 64'hC008000000000000);
        // overflow and subnormal edges
        add_row(op_add, rm_rne, 64'h7FEFFFFFFFFFFFFF, 64'h7FEFFFFFFFFFFFFF, 64'h7FF0000000000000);
        add_row(op_add, rm_rne, 64'h0000000000000001, 64'h0000000000000002, 64'h0000000000000003);
        add_row(op_add, rm_rne, 64'h000FFFFFFFFFFFFF, 64'h0000000000000001, 64'h0010000000000000);
        add_row(op_sub, rm_rne, 64'h0000000000000005, 64'h0000000000000005, 64'h0000000000000000);
        add_random_rows(10);
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b1;                // reset has to keep this out of the pipe
        req      = '0;
        build_table();
        limit = rows.size() + 5 + 20;
        repeat (4) @(posedge clk);
        rst      <= 1'b0;
        in_valid <= 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            in_valid <= 1'b1;
            req.op   <= rows[i].op;
            req.rm   <= rows[i].rm;
            req.tag  <= tag_w'(i);      // row index as tag
            req.a    <= rows[i].a;
            req.b    <= rows[i].b;
            i_checker.push_expected(tag_w'(i), rows[i].expv);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (i_checker.pending() != 0) @(posedge clk);
        repeat (3) @(posedge clk);      // room for a stray result
        done = 1'b1;
        i_checker.report_counts(i_fpu_top.i_props.fail_count);
        if (i_checker.n_fail == 0 && i_fpu_top.i_props.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (!rst) cycles <= cycles + 1;
        if (!done && cycles > limit) begin
            $display("timeout after %0d cycles with %0d results still outstanding",
                     cycles, i_checker.pending());
            i_checker.report_counts(i_fpu_top.i_props.fail_count);
            $display("Test failed");
            $finish;
        end
    end

endmodule

/* tb.f */
fpu_pkg.sv
fpu_unpack.sv
fpu_align.sv
fpu_calc.sv
fpu_normalize.sv
fpu_round_pack.sv
fpu_top.sv
fpu_props.sv
fpu_checker.sv
tb_fpu.sv

/* Makefile */
# Verilator build, run and lint for the binary64 pipeline testbench
TOP = tb_fpu

.PHONY: all lint clean

all:
	verilator --binary --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "Test passed" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log
